// ==== logic/sbusPkg.sv ====
// SBUS bus-level definitions
// Word and address widths plus the request and response bundles seen by a memory slave

package sbusPkg;

  localparam int WORD_BITS  = 36;       // Data word width on the bus
  localparam int ADR_BITS   = 22;       // Word address width on the bus
  localparam int QUAD_WORDS = 4;        // Words in one quadword transfer

  // One bus data word
  typedef logic [WORD_BITS-1:0] sbusWord;

  // Inputs driven by the bus master
  typedef struct packed {
    logic                  startA;      // Phase A start
    logic                  startB;      // Phase B start
    logic [ADR_BITS-1:0]   adr;         // Word address, low two bits pick the first word
    logic [QUAD_WORDS-1:0] rq;          // Word request mask, bit 0 sent first
  } sbusReq;

  // Outputs returned to the bus master
  typedef struct packed {
    logic    acknA;                     // Phase A acknowledge
    logic    acknB;                     // Phase B acknowledge
    logic    validA;                    // Phase A data valid
    logic    validB;                    // Phase B data valid
    sbusWord d;                         // Shared data lines
    logic    dataPar;                   // XOR of all data bits
  } sbusRsp;

endpackage

// ==== logic/memPkg.sv ====
// Memory-side definitions
// Store geometry, configuration register map and the phase read request

package memPkg;

  localparam int MEM_ADR_BITS = 18;                     // 256K words
  localparam int MEM_WORDS    = 1 << MEM_ADR_BITS;
  // Address bits above the store select the window
  localparam int WIN_BITS     = sbusPkg::ADR_BITS - MEM_ADR_BITS;

  // Configuration register addresses
  localparam logic CFG_ENABLE = 1'b0;
  localparam logic CFG_WINDOW = 1'b1;

  // Configuration state held by the register block
  typedef struct packed {
    logic                enable;        // Answer bus requests at all
    logic [WIN_BITS-1:0] window;        // Which window of the bus space we own
  } memCfg;

  // Read request from one phase into the store
  typedef struct packed {
    logic                    active;    // Phase is sending a word this cycle
    logic [MEM_ADR_BITS-1:0] storeAdr;  // Word to read
  } phaseRead;

endpackage

// ==== logic/memCtrlRegs.sv ====
// Memory configuration registers
// Holds enable and window number, decides which phase starts fall in our window
`timescale 1ns/1ps

module memCtrlRegs (
  input  logic                          SBUS,
  input  logic                          arstN,
  input  logic                          cfgWe,
  input  logic                          cfgAddr,
  input  logic [3:0]                    cfgWData,
  output logic [3:0]                    cfgRData,
  input  logic [sbusPkg::ADR_BITS-1:0]  adr,
  input  logic                          startA,
  input  logic                          startB,
  output logic                          hitA,
  output logic                          hitB
);

  memPkg::memCfg cfg;                   // Enable and window registers
  logic          winMatch;              // Address lies in our window

  always_ff @(posedge SBUS or negedge arstN) begin
    if (!arstN) begin
      cfg <= '0;                        // Disabled, window 0
    end else if (cfgWe) begin
      if (cfgAddr == memPkg::CFG_ENABLE)
        cfg.enable <= cfgWData[0];
      else
        cfg.window <= cfgWData[memPkg::WIN_BITS-1:0];
    end
  end

  // Read-back, enable sits in bit 0
  always_comb begin
    if (cfgAddr == memPkg::CFG_WINDOW)
      cfgRData = cfg.window;
    else
      cfgRData = {3'b000, cfg.enable};
  end

  // Window bits are the ones above the store address
  assign winMatch = cfg.enable &&
                    (adr[sbusPkg::ADR_BITS-1:memPkg::MEM_ADR_BITS] == cfg.window);

  assign hitA = startA & winMatch;      // Phase A start addressed to us
  assign hitB = startB & winMatch;      // Phase B start addressed to us

endmodule

// ==== logic/memPhase.sv ====
// One SBUS read phase
// Captures start, address and mask, then walks the quadword ack/valid sequence
`timescale 1ns/1ps

module memPhase (
  input  logic                               SBUS,
  input  logic                               arstN,
  input  logic                               start,
  input  logic                               hit,
  input  logic [sbusPkg::ADR_BITS-1:0]       adr,
  input  logic [sbusPkg::QUAD_WORDS-1:0]     rq,
  output logic                               ackn,
  output logic                               valid,
  output memPkg::phaseRead                   rd
);

  logic [memPkg::MEM_ADR_BITS-3:0] quadBase;   // Store quadword we read from
  logic [1:0]                      wordOfs;    // Rolling word offset, mod 4
  logic [sbusPkg::QUAD_WORDS-1:0]  toSend;     // Words still to go, head in bit 0

  // Control state, a start always reloads and drops any running sequence
  always_ff @(posedge SBUS or negedge arstN) begin
    if (!arstN) begin
      wordOfs <= '0;
      toSend  <= '0;
    end else if (start) begin
      wordOfs <= adr[1:0];              // First word of the quad
      toSend  <= hit ? rq : '0;         // Not ours, so nothing to send
    end else if (toSend != '0) begin
      wordOfs <= wordOfs + 2'd1;        // Wraps within the quad
      toSend  <= toSend >> 1;
    end
  end

  // Quad base is payload only, loaded with the start
  always_ff @(posedge SBUS) begin
    if (start)
      quadBase <= adr[memPkg::MEM_ADR_BITS-1:2];
  end

  // Head bit of the mask drives both strobes in the same cycle
  assign ackn  = toSend[0];
  assign valid = toSend[0];

  assign rd.active   = toSend[0];
  assign rd.storeAdr = {quadBase, wordOfs};

endmodule

// ==== logic/wordStore.sv ====
// Core word store
// 256K x 36 array, one load port and one combinational read port per phase
`timescale 1ns/1ps

module wordStore (
  input  logic                              SBUS,
  input  logic                              loadEn,
  input  logic [memPkg::MEM_ADR_BITS-1:0]   loadAdr,
  input  sbusPkg::sbusWord                  loadData,
  input  memPkg::phaseRead                  rdA,
  input  memPkg::phaseRead                  rdB,
  output sbusPkg::sbusWord                  wordA,
  output sbusPkg::sbusWord                  wordB
);

  sbusPkg::sbusWord mem [memPkg::MEM_WORDS];   // Contents survive reset

  // Load path, one word per cycle
  always_ff @(posedge SBUS) begin
    if (loadEn)
      mem[loadAdr] <= loadData;
  end

  // Asynchronous reads so data goes out with its ackn
  always_comb begin
    if (rdA.active)
      wordA = mem[rdA.storeAdr];
    else
      wordA = '0;                       // Quiet when phase idle
  end

  always_comb begin
    if (rdB.active)
      wordB = mem[rdB.storeAdr];
    else
      wordB = '0;
  end

endmodule

// ==== logic/busReturn.sv ====
// SBUS data return path
// Merges both phases onto the data lines with A first, adds parity
`timescale 1ns/1ps

module busReturn (
  input  logic             validA,
  input  logic             validB,
  input  sbusPkg::sbusWord wordA,
  input  sbusPkg::sbusWord wordB,
  output sbusPkg::sbusWord d,
  output logic             dataPar
);

  // Phase A wins when both are valid
  always_comb begin
    if (validA)
      d = wordA;
    else if (validB)
      d = wordB;
    else
      d = '0;                           // Lines held low when idle
  end

  // XOR over all 36 bits, zero for zero data
  assign dataPar = ^d;

endmodule

// ==== logic/sbusMemTop.sv ====
// SBUS core memory slave
// Configuration registers, two read phases, word store and data return
`timescale 1ns/1ps

module sbusMemTop (
  input  logic                             SBUS,
  input  logic                             arstN,
  input  sbusPkg::sbusReq                  req,
  output sbusPkg::sbusRsp                  rsp,
  input  logic                             cfgWe,
  input  logic                             cfgAddr,
  input  logic [3:0]                       cfgWData,
  output logic [3:0]                       cfgRData,
  input  logic                             loadEn,
  input  logic [memPkg::MEM_ADR_BITS-1:0]  loadAdr,
  input  sbusPkg::sbusWord                 loadData
);

  logic             hitA, hitB;         // Start addressed to this memory
  memPkg::phaseRead rdA, rdB;           // Phase read requests
  sbusPkg::sbusWord wordA, wordB;       // Store read data

  memCtrlRegs uCtrlRegs (
    .SBUS     (SBUS),
    .arstN    (arstN),
    .cfgWe    (cfgWe),
    .cfgAddr  (cfgAddr),
    .cfgWData (cfgWData),
    .cfgRData (cfgRData),
    .adr      (req.adr),
    .startA   (req.startA),
    .startB   (req.startB),
    .hitA     (hitA),
    .hitB     (hitB)
  );

  memPhase uPhaseA (
    .SBUS  (SBUS),
    .arstN (arstN),
    .start (req.startA),
    .hit   (hitA),
    .adr   (req.adr),
    .rq    (req.rq),
    .ackn  (rsp.acknA),
    .valid (rsp.validA),
    .rd    (rdA)
  );

  memPhase uPhaseB (
    .SBUS  (SBUS),
    .arstN (arstN),
    .start (req.startB),
    .hit   (hitB),
    .adr   (req.adr),
    .rq    (req.rq),
    .ackn  (rsp.acknB),
    .valid (rsp.validB),
    .rd    (rdB)
  );

  wordStore uStore (
    .SBUS     (SBUS),
    .loadEn   (loadEn),
    .loadAdr  (loadAdr),
    .loadData (loadData),
    .rdA      (rdA),
    .rdB      (rdB),
    .wordA    (wordA),
    .wordB    (wordB)
  );

  busReturn uReturn (
    .validA  (rsp.validA),
    .validB  (rsp.validB),
    .wordA   (wordA),
    .wordB   (wordB),
    .d       (rsp.d),
    .dataPar (rsp.dataPar)
  );

endmodule

// ==== test/tbVectors.svh ====
// SBUS memory test vectors
// Row table for the table-driven loop, plus the data pattern and per-cycle prediction
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// One test row with up to two starts a few cycles apart
typedef struct packed {
  logic       ph1;                      // First start phase with 0 for A and 1 for B
  logic       cfgEn;                    // Enable written before the starts
  logic [3:0] cfgWin;                   // Window written before the starts
  logic [3:0] adrWin;                   // Window bits placed on the address
  logic [3:0] slot1;                    // Index into the preloaded quad bases
  logic [1:0] ofs1;                     // First word offset
  logic [3:0] rq1;                      // Word mask
  logic       expHit;                   // Both starts should be answered
  logic [1:0] dly;                      // Cycles to the second start or 0 for none
  logic       ph2;
  logic [3:0] slot2;
  logic [1:0] ofs2;
  logic [3:0] rq2;
} vecRow;

localparam int NUM_VECS = 10;
vecRow vecs [NUM_VECS];

function automatic vecRow makeRow(input logic ph1, input logic en, input logic [3:0] win,
                                  input logic [3:0] aw, input logic [3:0] s1,
                                  input logic [1:0] o1, input logic [3:0] r1,
                                  input logic hit, input logic [1:0] dly, input logic ph2,
                                  input logic [3:0] s2, input logic [1:0] o2,
                                  input logic [3:0] r2);
  vecRow r;
  r.ph1    = ph1;
  r.cfgEn  = en;
  r.cfgWin = win;
  r.adrWin = aw;
  r.slot1  = s1;
  r.ofs1   = o1;
  r.rq1    = r1;
  r.expHit = hit;
  r.dly    = dly;
  r.ph2    = ph2;
  r.slot2  = s2;
  r.ofs2   = o2;
  r.rq2    = r2;
  return r;
endfunction

task automatic fillTable();
  // ph1 en win aw slot1 ofs1 rq1 hit dly ph2 slot2 ofs2 rq2
  vecs[0] = makeRow(0, 1, 5, 5, 0,  2, 4'b1111, 1, 0, 0, 0,  0, 4'b0000); // Full quad on A
  vecs[1] = makeRow(1, 1, 5, 5, 1,  1, 4'b0101, 1, 0, 0, 0,  0, 4'b0000); // Sparse on B
  vecs[2] = makeRow(1, 1, 5, 5, 2,  3, 4'b1010, 1, 0, 0, 0,  0, 4'b0000);
  vecs[3] = makeRow(0, 1, 5, 6, 3,  0, 4'b1111, 0, 0, 0, 0,  0, 4'b0000); // Outside window
  vecs[4] = makeRow(0, 0, 5, 5, 4,  0, 4'b1111, 0, 0, 0, 0,  0, 4'b0000); // Disabled
  vecs[5] = makeRow(0, 1, 6, 6, 5,  1, 4'b1111, 1, 0, 0, 0,  0, 4'b0000); // New window answers
  vecs[6] = makeRow(0, 1, 6, 6, 6,  0, 4'b1111, 1, 1, 1, 7,  2, 4'b1111); // A then B
  vecs[7] = makeRow(1, 1, 6, 6, 8,  3, 4'b1011, 1, 1, 0, 9,  0, 4'b0111); // B then A
  vecs[8] = makeRow(0, 1, 6, 6, 10, 0, 4'b1111, 1, 2, 0, 11, 3, 4'b1101); // Reload on A
  vecs[9] = makeRow(1, 1, 6, 6, 12, 1, 4'b1111, 1, 1, 1, 13, 2, 4'b0011); // Reload on B
endtask

// Preload pattern of store address times 3 plus 5
function automatic sbusPkg::sbusWord patternWord(input logic [memPkg::MEM_ADR_BITS-1:0] a);
  return {18'd0, a} * 36'd3 + 36'd5;
endfunction

// Valid flag and word for one phase in cycle c after the first start edge
function automatic logic [36:0] predictPhase(input vecRow r, input logic ph, input int c);
  int         s;
  int         k;
  logic [3:0] rq;
  logic [1:0] ofs;
  logic [3:0] slot;
  logic [1:0] wordOfs;
  s    = -1;
  rq   = '0;
  ofs  = '0;
  slot = '0;
  if (r.ph1 == ph) begin
    s    = 0;
    rq   = r.rq1;
    ofs  = r.ofs1;
    slot = r.slot1;
  end
  // A later start on the same phase takes over from its edge on
  if (r.dly != 0 && r.ph2 == ph && c >= r.dly) begin
    s    = r.dly;
    rq   = r.rq2;
    ofs  = r.ofs2;
    slot = r.slot2;
  end
  if (s < 0 || !r.expHit)
    return '0;
  k = c - s;
  if (k > 3 || !rq[k])
    return '0;
  wordOfs = ofs + k[1:0];               // Wraps inside the quad
  return {1'b1, patternWord({quadBase[slot], wordOfs})};
endfunction

`endif

// ==== test/tbSbusMem.sv ====
// Testbench for the SBUS core memory slave
// Preloads scattered quads, then runs the vector table through both phases
`timescale 1ns/1ps

module tbSbusMem;

  logic                            SBUS;
  logic                            arstN;
  sbusPkg::sbusReq                 req;
  sbusPkg::sbusRsp                 rsp;
  logic                            cfgWe;
  logic                            cfgAddr;
  logic [3:0]                      cfgWData;
  logic [3:0]                      cfgRData;
  logic                            loadEn;
  logic [memPkg::MEM_ADR_BITS-1:0] loadAdr;
  sbusPkg::sbusWord                loadData;

  logic [memPkg::MEM_ADR_BITS-3:0] quadBase [16];  // Random quads that hold data
  int                              mismatches;
  int                              timeouts;

  `include "tbVectors.svh"

  sbusMemTop u_sbusMemTop (
    .SBUS     (SBUS),
    .arstN    (arstN),
    .req      (req),
    .rsp      (rsp),
    .cfgWe    (cfgWe),
    .cfgAddr  (cfgAddr),
    .cfgWData (cfgWData),
    .cfgRData (cfgRData),
    .loadEn   (loadEn),
    .loadAdr  (loadAdr),
    .loadData (loadData)
  );

  initial begin
    SBUS = 1'b0;
    forever #20 SBUS = ~SBUS;           // 40 ns period
  end

  // Inputs change just after the rising edge
  task automatic nextDrive();
    @(posedge SBUS);
    #2;
  endtask

  task automatic checkVal(input string name, input logic [35:0] expV, input logic [35:0] actV);
    if (actV !== expV) begin
      mismatches++;
      $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, expV, actV);
    end
  endtask

  // Bounded wait until neither phase sends data
  task automatic waitIdle();
    int n;
    n = 0;
    @(negedge SBUS);
    while ((rsp.validA || rsp.validB) && n < 16) begin
      @(negedge SBUS);
      n++;
    end
    if (rsp.validA || rsp.validB) begin
      timeouts++;
      $display("ERROR t=%0t bus still sending data after 16 cycles", $time);
    end
  endtask

  task automatic writeCfg(input logic a, input logic [3:0] v);
    nextDrive();
    cfgWe    = 1'b1;
    cfgAddr  = a;
    cfgWData = v;
    nextDrive();                        // Written at the edge in between
    cfgWe    = 1'b0;
  endtask

  task automatic checkCfg(input logic en, input logic [3:0] win);
    nextDrive();
    cfgAddr = memPkg::CFG_ENABLE;
    @(negedge SBUS);
    checkVal("cfgRData(enable)", {3'b000, en}, cfgRData);
    nextDrive();
    cfgAddr = memPkg::CFG_WINDOW;
    @(negedge SBUS);
    checkVal("cfgRData(window)", win, cfgRData);
  endtask

  // 16 scattered quads of four words each
  task automatic preload();
    logic [31:0] rnd;
    for (int i = 0; i < 16; i++) begin
      rnd = $urandom();
      quadBase[i] = rnd[15:0];
      for (int w = 0; w < 4; w++) begin
        nextDrive();
        loadEn   = 1'b1;
        loadAdr  = {quadBase[i], w[1:0]};
        loadData = patternWord({quadBase[i], w[1:0]});
      end
    end
    nextDrive();
    loadEn = 1'b0;
  endtask

  task automatic driveStart(input logic ph, input logic [3:0] aw, input logic [3:0] slot,
                            input logic [1:0] ofs, input logic [3:0] rq);
    req.startA = (ph == 1'b0);
    req.startB = (ph == 1'b1);
    req.adr    = {aw, quadBase[slot], ofs};
    req.rq     = rq;
  endtask

  task automatic runRow(input vecRow r);
    logic [36:0]      pa;
    logic [36:0]      pb;
    sbusPkg::sbusWord expD;
    waitIdle();
    writeCfg(memPkg::CFG_ENABLE, {3'b000, r.cfgEn});
    writeCfg(memPkg::CFG_WINDOW, r.cfgWin);
    checkCfg(r.cfgEn, r.cfgWin);
    nextDrive();
    driveStart(r.ph1, r.adrWin, r.slot1, r.ofs1, r.rq1);  // Sampled at edge 0
    for (int c = 0; c < 8; c++) begin
      nextDrive();
      req = '0;
      if (r.dly != 0 && c + 1 == r.dly)
        driveStart(r.ph2, r.adrWin, r.slot2, r.ofs2, r.rq2);
      @(negedge SBUS);                  // Cycle c outputs settled
      pa = predictPhase(r, 1'b0, c);
      pb = predictPhase(r, 1'b1, c);
      if (pa[36])
        expD = pa[35:0];                // A has the lines when both send
      else if (pb[36])
        expD = pb[35:0];
      else
        expD = '0;
      checkVal("rsp.acknA", pa[36], rsp.acknA);
      checkVal("rsp.validA", pa[36], rsp.validA);
      checkVal("rsp.acknB", pb[36], rsp.acknB);
      checkVal("rsp.validB", pb[36], rsp.validB);
      checkVal("rsp.d", expD, rsp.d);
      checkVal("rsp.dataPar", ^expD, rsp.dataPar);
    end
  endtask

  initial begin
    void'($urandom(49847));
    mismatches = 0;
    timeouts   = 0;
    arstN      = 1'b0;
    req        = '0;
    cfgWe      = 1'b0;
    cfgAddr    = 1'b0;
    cfgWData   = '0;
    loadEn     = 1'b0;
    loadAdr    = '0;
    loadData   = '0;
    fillTable();

    repeat (4) @(posedge SBUS);
    #2;
    arstN = 1'b1;

    // Quiet bus and cleared configuration out of reset
    @(negedge SBUS);
    checkVal("rsp.acknA", 1'b0, rsp.acknA);
    checkVal("rsp.acknB", 1'b0, rsp.acknB);
    checkVal("rsp.validA", 1'b0, rsp.validA);
    checkVal("rsp.validB", 1'b0, rsp.validB);
    checkVal("rsp.d", '0, rsp.d);
    checkVal("rsp.dataPar", 1'b0, rsp.dataPar);
    checkCfg(1'b0, 4'd0);

    preload();
    for (int i = 0; i < NUM_VECS; i++)
      runRow(vecs[i]);
    waitIdle();

    $display("Checks done with %0d mismatches and %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+test
logic/sbusPkg.sv
logic/memPkg.sv
logic/memCtrlRegs.sv
logic/memPhase.sv
logic/wordStore.sv
logic/busReturn.sv
logic/sbusMemTop.sv
test/tbSbusMem.sv

// ==== Bender.yml ====
package:
  name: sbus_mem

sources:
  # Packages first, memPkg uses sbusPkg
  - logic/sbusPkg.sv
  - logic/memPkg.sv
  - logic/memCtrlRegs.sv
  - logic/memPhase.sv
  - logic/wordStore.sv
  - logic/busReturn.sv
  - logic/sbusMemTop.sv

  - target: test
    include_dirs:
      - test
    files:
      - test/tbSbusMem.sv
